// File: opm_timers.f
+incdir+design
design/opm_bus_pkg.sv
design/opm_timer_pkg.sv
design/opm_control.sv
design/opm_timer_a.sv
design/opm_timer_b.sv
design/opm_irq_status.sv
design/opm_timers.sv
verification/opm_timers_sva.sv
verification/opm_timers_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the opm timer testbench with verilator and run it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module opm_timers_tb \
    -f opm_timers.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vopm_timers_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "test failed" "$LOG"; then
    exit 1
fi
if ! grep -q "test passed" "$LOG"; then
    echo "simulation log holds no result"
    exit 1
fi
exit 0

// File: verification/opm_timers_tb.sv
`timescale 1ns/1ps
`include "opm_timer_cfg.svh"

module opm_timers_tb;

    localparam int NUM_TESTS = 6;

    logic                   clk = 1'b0;
    logic                   rst_n, cs_n, rd_n, wr_n, a0;
    opm_bus_pkg::opm_byte_t d, o_d;
    logic                   o_d_oe, o_ct1, o_ct2, o_irq_n;

    // stimulus table
    string       names [NUM_TESTS];
    bit          tmr_b [NUM_TESTS];     // 0 for timer A and 1 for timer B
    int          load_n [NUM_TESTS];
    bit          irq_en [NUM_TESTS];
    int          period_cyc [NUM_TESTS];
    logic [7:0]  ct_vals [4] = '{8'hC0, 8'h40, 8'h80, 8'h00};

    int          cyc = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          wd_limit;
    int unsigned lcg_state;
    bit          table_ready = 1'b0;

    opm_timers uut (
        .i_emuclk (clk    ),
        .i_rst_n  (rst_n  ),
        .i_cs_n   (cs_n   ),
        .i_rd_n   (rd_n   ),
        .i_wr_n   (wr_n   ),
        .i_a0     (a0     ),
        .i_d      (d      ),
        .o_d      (o_d    ),
        .o_d_oe   (o_d_oe ),
        .o_ct1    (o_ct1  ),
        .o_ct2    (o_ct2  ),
        .o_irq_n  (o_irq_n)
    );

    always #4 clk = ~clk;                   // 8 ns period
    always @(posedge clk) cyc <= cyc + 1;

    // read enable watched on every cycle
    always @(negedge clk) begin
        if (rst_n)
            check_val("read_enable", int'(!cs_n && !rd_n), int'(o_d_oe));
    end

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int period_cycles(input bit is_b, input int n);
        if (is_b)
            return `OPM_TMRB_PRESCALE * (256 - n) * `OPM_SLOTS;
        return (1024 - n) * `OPM_SLOTS;
    endfunction

    task automatic check_val(input string name, input int expected, input int actual);
        checks = checks + 1;
        if (expected != actual) begin
            errors = errors + 1;
            $display("FAIL %s: expected %0d, got %0d", name, expected, actual);
        end
    endtask

    task automatic add_entry(input int i, input string name, input bit is_b,
                             input int n, input bit en);
        names[i]      = name;
        tmr_b[i]      = is_b;
        load_n[i]     = n;
        irq_en[i]     = en;
        period_cyc[i] = period_cycles(is_b, n);
    endtask

    //////////////////////////////
    // bus cycles

    task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
        @(posedge clk);
        cs_n <= 1'b0;
        wr_n <= 1'b0;
        a0   <= 1'b0;
        d    <= addr;                       // address cycle
        @(posedge clk);
        a0   <= 1'b1;
        d    <= data;                       // data cycle
        @(negedge clk);
        check_val("oe_during_write", 0, int'(o_d_oe));
        @(posedge clk);
        cs_n <= 1'b1;
        wr_n <= 1'b1;
        a0   <= 1'b0;
    endtask

    task automatic status_read(output logic [7:0] val);
        @(posedge clk);
        cs_n <= 1'b0;
        rd_n <= 1'b0;
        @(negedge clk);
        check_val("oe_during_read", 1, int'(o_d_oe));
        val = o_d;
        @(posedge clk);
        cs_n <= 1'b1;
        rd_n <= 1'b1;
    endtask

    // stamp is the cycle of the flag's rising edge or -1 if none came
    task automatic wait_rise(input bit is_b, input int limit, output int stamp);
        logic prev;
        logic cur;
        int   n;
        stamp = -1;
        n     = 0;
        @(negedge clk);
        prev = is_b ? o_d[1] : o_d[0];
        while (n < limit && stamp < 0) begin
            @(negedge clk);
            cur = is_b ? o_d[1] : o_d[0];
            if (cur && !prev)
                stamp = cyc;
            prev = cur;
            n    = n + 1;
        end
    endtask

    task automatic run_entry(input int i);
        int         errs_before, t0, t1, high, ovfl;
        logic [7:0] ctl, frst, st;
        errs_before = errors;
        ctl  = tmr_b[i] ? 8'h02 : 8'h01;
        frst = tmr_b[i] ? 8'h20 : 8'h10;
        if (irq_en[i])
            ctl = ctl | (tmr_b[i] ? 8'h08 : 8'h04);
        bus_write(`OPM_ADDR_TMRCTRL, 8'h30);        // stop both and clear flags
        if (tmr_b[i]) begin
            bus_write(`OPM_ADDR_CLKB, 8'(load_n[i]));
        end else begin
            bus_write(`OPM_ADDR_CLKA1, 8'(load_n[i] >> 2));
            bus_write(`OPM_ADDR_CLKA2, 8'(load_n[i] & 3));
        end
        bus_write(`OPM_ADDR_TMRCTRL, ctl);
        if (irq_en[i]) begin
            wait_rise(tmr_b[i], 2 * period_cyc[i] + 64, t0);
            if (t0 < 0) begin
                errors = errors + 1;
                $display("%s: flag never rose after the timer was started", names[i]);
            end else begin
                status_read(st);
                check_val({names[i], "_status"}, tmr_b[i] ? 2 : 1, int'(st));
                @(negedge clk);
                check_val({names[i], "_irq_low"}, 0, int'(o_irq_n));
                bus_write(`OPM_ADDR_TMRCTRL, ctl | frst);
                repeat (2) @(negedge clk);          // strobe then clear
                check_val({names[i], "_cleared"}, 0, int'(o_d[1:0]));
                check_val({names[i], "_irq_high"}, 1, int'(o_irq_n));
                wait_rise(tmr_b[i], 2 * period_cyc[i] + 64, t1);
                if (t1 < 0) begin
                    errors = errors + 1;
                    $display("%s: flag did not rise again after being cleared", names[i]);
                end else begin
                    check_val(names[i], period_cyc[i], t1 - t0);
                end
            end
        end else begin
            high = 0;
            ovfl = 0;
            // flag stays quiet over two full periods while the timer wraps
            repeat (2 * period_cyc[i] + `OPM_SLOTS) begin
                @(negedge clk);
                if ((|o_d[1:0]) || !o_irq_n)
                    high = high + 1;
                if (tmr_b[i] ? uut.ovfl_b : uut.ovfl_a)
                    ovfl = ovfl + 1;
            end
            check_val({names[i], "_flag_quiet"}, 0, high);
            check_val({names[i], "_overflows"}, 2, ovfl);
        end
        $display("%s: %s", names[i], (errors == errs_before) ? "ok" : "mismatch");
        tests = tests + 1;
    endtask

    //////////////////////////////
    // watchdog

    initial begin
        wait (table_ready);
        wd_limit = 1000;
        for (int i = 0; i < NUM_TESTS; i++)
            wd_limit = wd_limit + 2 * period_cyc[i];
        repeat (wd_limit) @(posedge clk);
        $display("simulation timed out after %0d cycles", wd_limit);
        $display("test failed");
        $finish;
    end

    //////////////////////////////
    // main sequence

    initial begin
        logic [7:0] st;
        int         errs_before;
        rst_n <= 1'b0;
        cs_n  <= 1'b1;
        rd_n  <= 1'b1;
        wr_n  <= 1'b1;
        a0    <= 1'b0;
        d     <= '0;

        lcg_state = 52;
        add_entry(0, "tmra_fixed", 1'b0, 1000, 1'b1);
        lcg_state = lcg_next(lcg_state);
        add_entry(1, "tmra_lcg", 1'b0, 1000 + int'((lcg_state >> 16) % 16), 1'b1);
        add_entry(2, "tmrb_fixed", 1'b1, 252, 1'b1);
        lcg_state = lcg_next(lcg_state);
        add_entry(3, "tmrb_lcg", 1'b1, 250 + int'((lcg_state >> 16) % 4), 1'b1);
        add_entry(4, "tmra_noirq", 1'b0, 1010, 1'b0);
        add_entry(5, "tmrb_noirq", 1'b1, 254, 1'b0);
        table_ready = 1'b1;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // reset state
        errs_before = errors;
        @(negedge clk);
        check_val("reset_irq_n", 1, int'(o_irq_n));
        check_val("reset_ct", 0, int'({o_ct2, o_ct1}));
        check_val("reset_oe", 0, int'(o_d_oe));
        status_read(st);
        check_val("reset_status", 0, int'(st));
        $display("reset: %s", (errors == errs_before) ? "ok" : "mismatch");
        tests = tests + 1;

        // ct pins take bit 7 to ct2 and bit 6 to ct1
        errs_before = errors;
        foreach (ct_vals[k]) begin
            bus_write(`OPM_ADDR_CT, ct_vals[k]);
            @(negedge clk);
            check_val("ct2", int'(ct_vals[k][7]), int'(o_ct2));
            check_val("ct1", int'(ct_vals[k][6]), int'(o_ct1));
        end
        $display("ct_pins: %s", (errors == errs_before) ? "ok" : "mismatch");
        tests = tests + 1;

        for (int i = 0; i < NUM_TESTS; i++)
            run_entry(i);

        @(posedge clk);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// File: verification/opm_timers_sva.sv
`timescale 1ns/1ps

module opm_timers_sva (
    input  logic                        i_emuclk,
    input  logic                        i_rst_n,
    input  logic                        i_cs_n,
    input  logic                        i_rd_n,
    input  logic                        i_d_oe,
    input  logic                        i_irq_n,
    input  logic                        i_tick,
    input  opm_bus_pkg::opm_status_t    i_status
);

    //////////////////////////////
    // bus side

    a_irq_flags: assert property (@(posedge i_emuclk) disable iff (!i_rst_n)
        i_irq_n == !(i_status[opm_bus_pkg::STAT_FLAG_A] || i_status[opm_bus_pkg::STAT_FLAG_B]))
        else $error("irq line disagrees with status flags");

    a_read_oe: assert property (@(posedge i_emuclk) disable iff (!i_rst_n)
        i_d_oe == (!i_cs_n && !i_rd_n))
        else $error("data output enable does not follow read strobes");

    a_busy_low: assert property (@(posedge i_emuclk) disable iff (!i_rst_n)
        !i_status[opm_bus_pkg::STAT_BUSY])
        else $error("busy bit set in status");

    //////////////////////////////
    // sequencer

    a_tick_single: assert property (@(posedge i_emuclk) disable iff (!i_rst_n)
        i_tick |=> !i_tick)
        else $error("timer tick high on two edges in a row");

endmodule

bind opm_timers opm_timers_sva u_sva (
    .i_emuclk   (i_emuclk   ),
    .i_rst_n    (i_rst_n    ),
    .i_cs_n     (i_cs_n     ),
    .i_rd_n     (i_rd_n     ),
    .i_d_oe     (o_d_oe     ),
    .i_irq_n    (o_irq_n    ),
    .i_tick     (tick       ),
    .i_status   (o_d        )
);

// File: design/opm_timers.sv
`timescale 1ns/1ps

module opm_timers (
    input  logic                        i_emuclk,
    input  logic                        i_rst_n,

    // bus
    input  logic                        i_cs_n,
    input  logic                        i_rd_n,
    input  logic                        i_wr_n,
    input  logic                        i_a0,
    input  opm_bus_pkg::opm_byte_t      i_d,
    output opm_bus_pkg::opm_byte_t      o_d,
    output logic                        o_d_oe,

    output logic                        o_ct1,
    output logic                        o_ct2,
    output logic                        o_irq_n
);

    opm_timer_pkg::tmr_ctrl_t   ctrl;
    opm_timer_pkg::tmra_val_t   clka;
    opm_timer_pkg::tmrb_val_t   clkb;
    logic                       tick;
    logic                       ovfl_a, ovfl_b;

    //////////////////////////////
    // blocks

    opm_control u_control (
        .i_emuclk   (i_emuclk   ),
        .i_rst_n    (i_rst_n    ),
        .i_cs_n     (i_cs_n     ),
        .i_wr_n     (i_wr_n     ),
        .i_a0       (i_a0       ),
        .i_d        (i_d        ),
        .o_ctrl     (ctrl       ),
        .o_clka     (clka       ),
        .o_clkb     (clkb       ),
        .o_ct1      (o_ct1      ),
        .o_ct2      (o_ct2      ),
        .o_tick     (tick       )
    );

    opm_timer_a u_timer_a (
        .i_emuclk   (i_emuclk   ),
        .i_rst_n    (i_rst_n    ),
        .i_tick     (tick       ),
        .i_run      (ctrl.run_a ),
        .i_load     (clka       ),
        .o_ovfl     (ovfl_a     )
    );

    opm_timer_b u_timer_b (
        .i_emuclk   (i_emuclk   ),
        .i_rst_n    (i_rst_n    ),
        .i_tick     (tick       ),
        .i_run      (ctrl.run_b ),
        .i_load     (clkb       ),
        .o_ovfl     (ovfl_b     )
    );

    opm_irq_status u_irq_status (
        .i_emuclk   (i_emuclk   ),
        .i_rst_n    (i_rst_n    ),
        .i_ovfl_a   (ovfl_a     ),
        .i_ovfl_b   (ovfl_b     ),
        .i_ctrl     (ctrl       ),
        .i_cs_n     (i_cs_n     ),
        .i_rd_n     (i_rd_n     ),
        .o_status   (o_d        ),   // status is the only readable byte
        .o_d_oe     (o_d_oe     ),
        .o_irq_n    (o_irq_n    )
    );

endmodule

// File: design/opm_irq_status.sv
`timescale 1ns/1ps

module opm_irq_status (
    input  logic                        i_emuclk,
    input  logic                        i_rst_n,

    input  logic                        i_ovfl_a,
    input  logic                        i_ovfl_b,
    input  opm_timer_pkg::tmr_ctrl_t    i_ctrl,

    // read side
    input  logic                        i_cs_n,
    input  logic                        i_rd_n,
    output opm_bus_pkg::opm_status_t    o_status,
    output logic                        o_d_oe,

    output logic                        o_irq_n
);

    logic flag_a, flag_b;

    //////////////////////////////
    // flag latches

    // clear beats set when both land together
    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
        end else begin
            if (i_ctrl.frst_a)
                flag_a <= 1'b0;
            else if (i_ovfl_a && i_ctrl.irqen_a)
                flag_a <= 1'b1;

            if (i_ctrl.frst_b)
                flag_b <= 1'b0;
            else if (i_ovfl_b && i_ctrl.irqen_b)
                flag_b <= 1'b1;
        end
    end

    always_comb begin
        o_status                           = '0;
        o_status[opm_bus_pkg::STAT_FLAG_A] = flag_a;
        o_status[opm_bus_pkg::STAT_FLAG_B] = flag_b;
        o_status[opm_bus_pkg::STAT_BUSY]   = 1'b0;   // no write latency to report
    end

    assign o_irq_n = !(flag_a || flag_b);
    assign o_d_oe  = !i_cs_n && !i_rd_n;

endmodule

// File: design/opm_timer_b.sv
`timescale 1ns/1ps
`include "opm_timer_cfg.svh"

module opm_timer_b (
    input  logic                        i_emuclk,
    input  logic                        i_rst_n,

    input  logic                        i_tick,     // one per sample
    input  logic                        i_run,
    input  opm_timer_pkg::tmrb_val_t    i_load,

    output logic                        o_ovfl
);

    opm_timer_pkg::tmrb_state_e                 state;
    opm_timer_pkg::tmrb_val_t                   cnt;
    logic [$clog2(`OPM_TMRB_PRESCALE)-1:0]      presc;      // ticks within one count
    logic                                       presc_done;

    assign presc_done = (presc == '1);  // every 16th tick

    //////////////////////////////
    // state, prescaler, counter

    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            state  <= opm_timer_pkg::TB_IDLE;
            cnt    <= '0;
            presc  <= '0;
            o_ovfl <= 1'b0;
        end else begin
            o_ovfl <= 1'b0;
            case (state)
                opm_timer_pkg::TB_IDLE: begin
                    cnt <= i_load;
                    if (i_run) begin
                        state <= opm_timer_pkg::TB_RUN;
                        presc <= '0;        // fresh prescale on start
                    end
                end
                opm_timer_pkg::TB_RUN: begin
                    if (!i_run) begin
                        state <= opm_timer_pkg::TB_IDLE;
                        cnt   <= i_load;
                    end else if (i_tick) begin
                        presc <= presc + 1'b1;
                        if (presc_done) begin
                            if (cnt == '1) begin
                                cnt    <= i_load;
                                o_ovfl <= 1'b1;
                            end else begin
                                cnt <= cnt + 1'b1;
                            end
                        end
                    end
                end
                default: state <= opm_timer_pkg::TB_IDLE;
            endcase
        end
    end

endmodule

// File: design/opm_timer_a.sv
`timescale 1ns/1ps

module opm_timer_a (
    input  logic                        i_emuclk,
    input  logic                        i_rst_n,

    input  logic                        i_tick,     // one per sample
    input  logic                        i_run,
    input  opm_timer_pkg::tmra_val_t    i_load,

    output logic                        o_ovfl
);

    opm_timer_pkg::tmra_val_t cnt;

    //////////////////////////////
    // load, count, overflow

    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            cnt    <= '0;
            o_ovfl <= 1'b0;
        end else begin
            o_ovfl <= 1'b0;                 // pulse by default low
            if (!i_run) begin
                cnt <= i_load;              // stopped, track the register
            end else if (i_tick) begin
                if (cnt == '1) begin
                    cnt    <= i_load;
                    o_ovfl <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: design/opm_control.sv
`timescale 1ns/1ps
`include "opm_timer_cfg.svh"

module opm_control (
    input  logic                    i_emuclk,
    input  logic                    i_rst_n,

    // bus
    input  logic                    i_cs_n,
    input  logic                    i_wr_n,
    input  logic                    i_a0,
    input  opm_bus_pkg::opm_byte_t  i_d,

    // to the timers
    output opm_timer_pkg::tmr_ctrl_t o_ctrl,
    output opm_timer_pkg::tmra_val_t o_clka,
    output opm_timer_pkg::tmrb_val_t o_clkb,

    // ct pins
    output logic                    o_ct1,
    output logic                    o_ct2,

    output logic                    o_tick      // once per sample
);

    opm_bus_pkg::opm_addr_t addr;
    opm_bus_pkg::opm_byte_t clka1;
    logic [1:0]             clka2;
    opm_bus_pkg::opm_byte_t clkb;
    logic                   run_a, run_b;
    logic                   irqen_a, irqen_b;
    logic                   frst_a, frst_b;
    opm_timer_pkg::slot_t   slot;
    logic                   tick_q;
    logic                   wr;
    logic                   wr_data;

    assign wr      = !i_cs_n && !i_wr_n;
    assign wr_data = wr && i_a0;

    //////////////////////////////
    // address latch and registers

    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            addr    <= '0;
            clka1   <= '0;
            clka2   <= '0;
            clkb    <= '0;
            run_a   <= 1'b0;
            run_b   <= 1'b0;
            irqen_a <= 1'b0;
            irqen_b <= 1'b0;
            o_ct1   <= 1'b0;
            o_ct2   <= 1'b0;
        end else if (wr && !i_a0) begin
            addr <= i_d;
        end else if (wr_data) begin
            case (addr)
                `OPM_ADDR_CLKA1:   clka1 <= i_d;
                `OPM_ADDR_CLKA2:   clka2 <= i_d[1:0];
                `OPM_ADDR_CLKB:    clkb  <= i_d;
                `OPM_ADDR_TMRCTRL: begin
                    run_a   <= i_d[0];
                    run_b   <= i_d[1];
                    irqen_a <= i_d[2];
                    irqen_b <= i_d[3];
                end
                `OPM_ADDR_CT: begin
                    o_ct2 <= i_d[7];
                    o_ct1 <= i_d[6];
                end
                default: ;          // other registers belong to the sound path
            endcase
        end
    end

    // flag reset bits are not stored, only pulsed
    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            frst_a <= 1'b0;
            frst_b <= 1'b0;
        end else begin
            frst_a <= wr_data && (addr == `OPM_ADDR_TMRCTRL) && i_d[4];
            frst_b <= wr_data && (addr == `OPM_ADDR_TMRCTRL) && i_d[5];
        end
    end

    //////////////////////////////
    // slot sequencer

    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            slot   <= '0;
            tick_q <= 1'b0;
        end else begin
            slot   <= slot + 1'b1;      // wraps after slot 31
            tick_q <= (slot == opm_timer_pkg::slot_t'(`OPM_SLOTS - 1));
        end
    end

    assign o_tick = tick_q;

    assign o_clka = {clka1, clka2};
    assign o_clkb = clkb;

    assign o_ctrl.run_a   = run_a;
    assign o_ctrl.run_b   = run_b;
    assign o_ctrl.irqen_a = irqen_a;
    assign o_ctrl.irqen_b = irqen_b;
    assign o_ctrl.frst_a  = frst_a;
    assign o_ctrl.frst_b  = frst_b;

endmodule

// File: design/opm_timer_pkg.sv
`include "opm_timer_cfg.svh"

package opm_timer_pkg;

    //////////////////////////////
    // timer counts and slot number

    typedef logic [`OPM_TMRA_W-1:0]         tmra_val_t;
    typedef logic [`OPM_TMRB_W-1:0]         tmrb_val_t;
    typedef logic [$clog2(`OPM_SLOTS)-1:0]  slot_t;

    // register 0x14 as seen by the timers
    // frst_a / frst_b are one-cycle strobes, the rest are held
    typedef struct packed {
        logic run_a;        // bit 0
        logic run_b;        // bit 1
        logic irqen_a;      // bit 2
        logic irqen_b;      // bit 3
        logic frst_a;       // bit 4
        logic frst_b;       // bit 5
    } tmr_ctrl_t;

    //////////////////////////////
    // timer B state

    typedef enum logic {
        TB_IDLE,            // held at load value
        TB_RUN
    } tmrb_state_e;

endpackage

// File: design/opm_bus_pkg.sv
package opm_bus_pkg;

    //////////////////////////////
    // host bus types

    typedef logic [7:0] opm_byte_t;     // data byte on the bus
    typedef logic [7:0] opm_addr_t;     // register address latched on a0 = 0

    // status byte seen on every read
    // only the two timer flags and the busy bit carry meaning
    typedef logic [7:0] opm_status_t;

    // status bit positions
    localparam int STAT_FLAG_A = 0;
    localparam int STAT_FLAG_B = 1;
    localparam int STAT_BUSY   = 7;     // busy is never raised here

endpackage

// File: design/opm_timer_cfg.svh
`ifndef OPM_TIMER_CFG_SVH
`define OPM_TIMER_CFG_SVH

// sequencer
`define OPM_SLOTS           32      // slots per sample
`define OPM_TMRB_PRESCALE   16      // timer B ticks per count

// timer widths
`define OPM_TMRA_W          10
`define OPM_TMRB_W          8

//////////////////////////////
// register map
`define OPM_ADDR_CLKA1      8'h10   // timer A bits 9..2
`define OPM_ADDR_CLKA2      8'h11   // timer A bits 1..0
`define OPM_ADDR_CLKB       8'h12
`define OPM_ADDR_TMRCTRL    8'h14
`define OPM_ADDR_CT         8'h1B   // ct2 on bit 7, ct1 on bit 6

`endif
